// ==== compile.f ====
rtl/if_pkg.sv
rtl/pc_redirect.sv
rtl/fetch_requester.sv
rtl/fetch_commit.sv
rtl/if_stage.sv
tests/imem_model.sv
tests/tb_if_stage.sv

// ==== rtl/fetch_commit.sv ====
`timescale 1ns/1ps

module fetch_commit (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    beat_fire_i,
    input  logic [if_pkg::XLEN-1:0] req_addr_i,
    input  logic [if_pkg::XLEN-1:0] rd_data_i,
    input  logic [if_pkg::XLEN-1:0] cur_pc_i,
    output logic                    pc_match_o,
    output logic                    inst_valid_o,
    output logic [if_pkg::ILEN-1:0] inst_o,
    output logic [if_pkg::XLEN-1:0] inst_pc_o
);
    import if_pkg::*;

    logic            inst_valid_q;
    logic [ILEN-1:0] inst_q;
    logic [XLEN-1:0] inst_pc_q;

    // a beat counts only if the pc has not moved since the request
    assign pc_match_o = beat_fire_i && (req_addr_i == cur_pc_i);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            inst_valid_q <= 1'b0;
        end else begin
            inst_valid_q <= pc_match_o;
        end
    end

    // lower word of the beat only
    always_ff @(posedge clk) begin
        if (pc_match_o) begin
            inst_q    <= rd_data_i[ILEN-1:0];
            inst_pc_q <= req_addr_i;
        end
    end

    assign inst_valid_o = inst_valid_q;
    assign inst_o       = inst_q;
    assign inst_pc_o    = inst_pc_q;

    // deliveries are separated by a full read round trip
    a_single_pulse: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        inst_valid_o |=> !inst_valid_o
    ) else $error("fetch_commit: inst_valid_o high two cycles in a row");

endmodule

// ==== rtl/fetch_requester.sv ====
`timescale 1ns/1ps

module fetch_requester (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic [if_pkg::XLEN-1:0] cur_pc_i,
    input  logic                    rd_addr_ready_i,
    input  logic                    rd_data_valid_i,
    output logic                    rd_addr_valid_o,
    output logic [if_pkg::XLEN-1:0] rd_addr_o,
    output logic                    rd_data_ready_o,
    output logic                    beat_fire_o,
    output logic [if_pkg::XLEN-1:0] req_addr_o
);
    import if_pkg::*;

    logic [1:0]      state_q;
    logic [1:0]      state_d;
    logic [XLEN-1:0] req_addr_q;
    logic            addr_fire;

    assign addr_fire   = rd_addr_valid_o && rd_addr_ready_i;
    assign beat_fire_o = rd_data_ready_o && rd_data_valid_i;

    // one read in flight at a time
    always_comb begin
        state_d = state_q;
        case (state_q)
            FR_RELAUNCH: begin
                state_d = FR_ISSUE;
            end
            FR_ISSUE: begin
                if (addr_fire) begin
                    state_d = FR_WAIT_DATA;
                end
            end
            FR_WAIT_DATA: begin
                if (beat_fire_o) begin
                    state_d = FR_RELAUNCH;
                end
            end
            default: begin
                state_d = FR_RELAUNCH;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= FR_RELAUNCH;
        end else begin
            state_q <= state_d;
        end
    end

    // capture the pc in the gap cycle, it already reflects the last beat
    always_ff @(posedge clk) begin
        if (state_q == FR_RELAUNCH) begin
            req_addr_q <= cur_pc_i;
        end
    end

    assign rd_addr_valid_o = (state_q == FR_ISSUE);
    assign rd_data_ready_o = (state_q == FR_WAIT_DATA);
    assign rd_addr_o       = req_addr_q;
    assign req_addr_o      = req_addr_q;

    // address must hold until the memory takes it
    a_addr_stable: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        rd_addr_valid_o && !rd_addr_ready_i |=> rd_addr_valid_o && $stable(rd_addr_o)
    ) else $error("fetch_requester: rd_addr_o changed while waiting");

    // address and data phases never overlap
    a_phase_excl: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        !(rd_addr_valid_o && rd_data_ready_o)
    ) else $error("fetch_requester: addr valid and data ready both high");

endmodule

// ==== rtl/if_pkg.sv ====
package if_pkg;

    // datapath widths
    localparam int XLEN = 64;
    localparam int ILEN = 32;

    // first fetch address after reset
    localparam logic [XLEN-1:0] RESET_PC = 64'h0000_0000_8000_0000;

    // byte strobe for a 32-bit instruction read
    localparam logic [7:0] RD_SIZE = 8'h0F;

    // sequential pc increment
    localparam logic [XLEN-1:0] INST_STEP = 64'd4;

    // read sequencer states
    localparam logic [1:0] FR_RELAUNCH  = 2'd0;
    localparam logic [1:0] FR_ISSUE     = 2'd1;
    localparam logic [1:0] FR_WAIT_DATA = 2'd2;

endpackage

// ==== rtl/if_stage.sv ====
`timescale 1ns/1ps

module if_stage (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    redirect_jal_i,
    input  logic                    redirect_branch_i,
    input  logic [if_pkg::XLEN-1:0] branch_cmp_i,
    input  logic                    redirect_jalr_i,
    input  logic [if_pkg::XLEN-1:0] jalr_base_i,
    input  logic                    trap_i,
    input  logic [if_pkg::XLEN-1:0] trap_vec_i,
    input  logic [if_pkg::XLEN-1:0] mem_pc_i,
    input  logic [if_pkg::XLEN-1:0] mem_imm_i,
    input  logic                    stall_i,
    input  logic                    rd_addr_ready_i,
    input  logic                    rd_data_valid_i,
    input  logic [if_pkg::XLEN-1:0] rd_data_i,
    output logic                    rd_addr_valid_o,
    output logic [if_pkg::XLEN-1:0] rd_addr_o,
    output logic [7:0]              rd_size_o,
    output logic                    rd_data_ready_o,
    output logic                    inst_valid_o,
    output logic [if_pkg::ILEN-1:0] inst_o,
    output logic [if_pkg::XLEN-1:0] inst_pc_o
);
    import if_pkg::*;

    logic [XLEN-1:0] cur_pc;
    logic [XLEN-1:0] req_addr;
    logic            beat_fire;
    logic            pc_match;

    // every fetch reads one instruction word
    assign rd_size_o = RD_SIZE;

    pc_redirect i_pc_redirect (
        .clk               (clk),
        .rst_n_i           (rst_n_i),
        .redirect_jal_i    (redirect_jal_i),
        .redirect_branch_i (redirect_branch_i),
        .branch_cmp_i      (branch_cmp_i),
        .redirect_jalr_i   (redirect_jalr_i),
        .jalr_base_i       (jalr_base_i),
        .trap_i            (trap_i),
        .trap_vec_i        (trap_vec_i),
        .mem_pc_i          (mem_pc_i),
        .mem_imm_i         (mem_imm_i),
        .stall_i           (stall_i),
        .pc_match_i        (pc_match),
        .cur_pc_o          (cur_pc)
    );

    fetch_requester i_fetch_requester (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .cur_pc_i        (cur_pc),
        .rd_addr_ready_i (rd_addr_ready_i),
        .rd_data_valid_i (rd_data_valid_i),
        .rd_addr_valid_o (rd_addr_valid_o),
        .rd_addr_o       (rd_addr_o),
        .rd_data_ready_o (rd_data_ready_o),
        .beat_fire_o     (beat_fire),
        .req_addr_o      (req_addr)
    );

    fetch_commit i_fetch_commit (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .beat_fire_i  (beat_fire),
        .req_addr_i   (req_addr),
        .rd_data_i    (rd_data_i),
        .cur_pc_i     (cur_pc),
        .pc_match_o   (pc_match),
        .inst_valid_o (inst_valid_o),
        .inst_o       (inst_o),
        .inst_pc_o    (inst_pc_o)
    );

endmodule

// ==== rtl/pc_redirect.sv ====
`timescale 1ns/1ps

module pc_redirect (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    redirect_jal_i,
    input  logic                    redirect_branch_i,
    input  logic [if_pkg::XLEN-1:0] branch_cmp_i,
    input  logic                    redirect_jalr_i,
    input  logic [if_pkg::XLEN-1:0] jalr_base_i,
    input  logic                    trap_i,
    input  logic [if_pkg::XLEN-1:0] trap_vec_i,
    input  logic [if_pkg::XLEN-1:0] mem_pc_i,
    input  logic [if_pkg::XLEN-1:0] mem_imm_i,
    input  logic                    stall_i,
    input  logic                    pc_match_i,
    output logic [if_pkg::XLEN-1:0] cur_pc_o
);
    import if_pkg::*;

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pc_d;
    logic [XLEN-1:0] jump_target;
    logic [XLEN-1:0] jalr_sum;
    logic            branch_taken;
    logic            seq_advance;

    // branch is taken when the compare result is zero
    assign branch_taken = redirect_branch_i && (branch_cmp_i == '0);

    // pc-relative target shared by jal and branch
    assign jump_target = mem_pc_i + mem_imm_i;

    // register-relative target, bit 0 dropped below
    assign jalr_sum = jalr_base_i + mem_imm_i;

    // only a delivered instruction of the current pc moves us on
    assign seq_advance = pc_match_i && !stall_i;

    always_comb begin
        pc_d = pc_q;
        if (redirect_jal_i || branch_taken) begin
            pc_d = jump_target;
        end else if (redirect_jalr_i) begin
            pc_d = {jalr_sum[XLEN-1:1], 1'b0};
        end else if (trap_i) begin
            pc_d = trap_vec_i;
        end else if (seq_advance) begin
            pc_d = pc_q + INST_STEP;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_d;
        end
    end

    assign cur_pc_o = pc_q;

    // every pc source keeps halfword alignment
    a_pc_aligned: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        cur_pc_o[0] == 1'b0
    ) else $error("pc_redirect: cur_pc_o misaligned %h", cur_pc_o);

endmodule

// ==== tests/imem_model.sv ====
`timescale 1ns/1ps

module imem_model #(
    parameter logic [if_pkg::XLEN-1:0] DATA_KEY = '0,
    parameter logic [31:0]             SEED     = 32'h482dbf4b
) (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    rd_addr_valid_i,
    input  logic [if_pkg::XLEN-1:0] rd_addr_i,
    input  logic [7:0]              rd_size_i,
    output logic                    rd_addr_ready_o,
    output logic                    rd_data_valid_o,
    output logic [if_pkg::XLEN-1:0] rd_data_o,
    input  logic                    rd_data_ready_i,
    output logic [31:0]             err_count_o
);
    import if_pkg::*;

    integer          seed;
    logic            pending_q;
    logic [XLEN-1:0] addr_q;
    logic [1:0]      addr_wait_q;
    logic [2:0]      data_wait_q;
    logic            held_q;
    logic [XLEN-1:0] held_addr_q;
    logic [31:0]     err_q;

    initial begin
        seed = SEED;
    end

    // one read at a time and ready only once the accept delay has run out
    assign rd_addr_ready_o = !pending_q && (addr_wait_q == 2'd0);
    assign rd_data_valid_o = pending_q && (data_wait_q == 3'd0);
    // memory contents are a pure function of the address
    assign rd_data_o       = addr_q ^ DATA_KEY;
    assign err_count_o     = err_q;

    always @(posedge clk or negedge rst_n_i) begin : mem_seq
        logic [31:0] rnd;
        if (!rst_n_i) begin
            pending_q   <= 1'b0;
            addr_q      <= '0;
            addr_wait_q <= 2'd0;
            data_wait_q <= 3'd0;
        end else begin
            if (rd_addr_valid_i && rd_addr_ready_o) begin
                rnd = $random(seed);
                pending_q   <= 1'b1;
                addr_q      <= rd_addr_i;
                // data after 1 to 4 cycles and next accept after 0 to 3
                data_wait_q <= 3'd1 + {1'b0, rnd[1:0]};
                addr_wait_q <= rnd[9:8];
            end else if (rd_addr_valid_i && addr_wait_q != 2'd0) begin
                addr_wait_q <= addr_wait_q - 2'd1;
            end
            if (pending_q && data_wait_q != 3'd0) begin
                data_wait_q <= data_wait_q - 3'd1;
            end
            if (rd_data_valid_o && rd_data_ready_i) begin
                pending_q <= 1'b0;
            end
        end
    end

    // request has to hold address and size until it is accepted
    always @(posedge clk or negedge rst_n_i) begin : bus_check
        int new_errs;
        if (!rst_n_i) begin
            held_q      <= 1'b0;
            held_addr_q <= '0;
            err_q       <= '0;
        end else begin
            new_errs = 0;
            if (rd_size_i !== RD_SIZE) begin
                $display("FAILED rd_size_o: expected %h, got %h", RD_SIZE, rd_size_i);
                new_errs++;
            end
            // data ready is high exactly while a read is outstanding
            if (rd_data_ready_i !== pending_q) begin
                $display("FAILED rd_data_ready_o: expected %h, got %h",
                         pending_q, rd_data_ready_i);
                new_errs++;
            end
            if (held_q && !rd_addr_valid_i) begin
                $display("read address valid dropped before the memory accepted it");
                new_errs++;
            end else if (held_q && rd_addr_i !== held_addr_q) begin
                $display("FAILED rd_addr_o: expected %h, got %h", held_addr_q, rd_addr_i);
                new_errs++;
            end
            held_q      <= rd_addr_valid_i && !rd_addr_ready_o;
            held_addr_q <= rd_addr_i;
            err_q       <= err_q + new_errs;
        end
    end

endmodule

// ==== tests/tb_if_stage.sv ====
`timescale 1ns/1ps

module tb_if_stage;
    import if_pkg::*;

    localparam logic [XLEN-1:0] MEM_KEY    = 64'h3c5a_96e1_0bad_f00d;
    localparam logic [31:0]     SEED_INIT  = 32'h482dbf4b;
    localparam int              WAIT_LIMIT = 400;

    logic            clk;
    logic            rst_n_i;
    logic            redirect_jal_i;
    logic            redirect_branch_i;
    logic [XLEN-1:0] branch_cmp_i;
    logic            redirect_jalr_i;
    logic [XLEN-1:0] jalr_base_i;
    logic            trap_i;
    logic [XLEN-1:0] trap_vec_i;
    logic [XLEN-1:0] mem_pc_i;
    logic [XLEN-1:0] mem_imm_i;
    logic            stall_i;
    logic            rd_addr_ready_i;
    logic            rd_data_valid_i;
    logic [XLEN-1:0] rd_data_i;
    logic            rd_addr_valid_o;
    logic [XLEN-1:0] rd_addr_o;
    logic [7:0]      rd_size_o;
    logic            rd_data_ready_o;
    logic            inst_valid_o;
    logic [ILEN-1:0] inst_o;
    logic [XLEN-1:0] inst_pc_o;
    logic [31:0]     mem_errors;

    integer          seed;
    int              error_count;
    int              check_count;
    int              delivered;
    logic [XLEN-1:0] exp_pc;
    logic [XLEN-1:0] hist_pc;
    logic [XLEN-1:0] hist_adv;

    if_stage i_if_stage (
        .clk               (clk),
        .rst_n_i           (rst_n_i),
        .redirect_jal_i    (redirect_jal_i),
        .redirect_branch_i (redirect_branch_i),
        .branch_cmp_i      (branch_cmp_i),
        .redirect_jalr_i   (redirect_jalr_i),
        .jalr_base_i       (jalr_base_i),
        .trap_i            (trap_i),
        .trap_vec_i        (trap_vec_i),
        .mem_pc_i          (mem_pc_i),
        .mem_imm_i         (mem_imm_i),
        .stall_i           (stall_i),
        .rd_addr_ready_i   (rd_addr_ready_i),
        .rd_data_valid_i   (rd_data_valid_i),
        .rd_data_i         (rd_data_i),
        .rd_addr_valid_o   (rd_addr_valid_o),
        .rd_addr_o         (rd_addr_o),
        .rd_size_o         (rd_size_o),
        .rd_data_ready_o   (rd_data_ready_o),
        .inst_valid_o      (inst_valid_o),
        .inst_o            (inst_o),
        .inst_pc_o         (inst_pc_o)
    );

    imem_model #(
        .DATA_KEY (MEM_KEY),
        .SEED     (SEED_INIT)
    ) i_imem_model (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .rd_addr_valid_i (rd_addr_valid_o),
        .rd_addr_i       (rd_addr_o),
        .rd_size_i       (rd_size_o),
        .rd_addr_ready_o (rd_addr_ready_i),
        .rd_data_valid_o (rd_data_valid_i),
        .rd_data_o       (rd_data_i),
        .rd_data_ready_i (rd_data_ready_o),
        .err_count_o     (mem_errors)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // redirect priority, then the sequential step
    function automatic logic [XLEN-1:0] next_expected_pc(
        input logic [XLEN-1:0] pc,
        input logic            jal,
        input logic            br,
        input logic [XLEN-1:0] cmp,
        input logic            jalr,
        input logic [XLEN-1:0] base,
        input logic            trap,
        input logic [XLEN-1:0] vec,
        input logic [XLEN-1:0] mpc,
        input logic [XLEN-1:0] imm,
        input logic            adv
    );
        logic [XLEN-1:0] sum;
        sum = base + imm;
        if (jal || (br && cmp == '0)) begin
            return mpc + imm;
        end
        if (jalr) begin
            return {sum[XLEN-1:1], 1'b0};
        end
        if (trap) begin
            return vec;
        end
        if (adv) begin
            return pc + INST_STEP;
        end
        return pc;
    endfunction

    // memory word for an address, low half is the instruction
    function automatic logic [ILEN-1:0] expected_inst(input logic [XLEN-1:0] addr);
        logic [XLEN-1:0] word;
        word = addr ^ MEM_KEY;
        return word[ILEN-1:0];
    endfunction

    // pc tracker, a delivery shows up one cycle after its match
    always @(posedge clk) begin : pc_tracker
        logic [XLEN-1:0] pc_now;
        if (!rst_n_i) begin
            exp_pc   <= RESET_PC;
            hist_pc  <= RESET_PC;
            hist_adv <= RESET_PC;
        end else begin
            pc_now = exp_pc;
            if (inst_valid_o) begin
                pc_now = hist_adv;
            end
            hist_pc  <= pc_now;
            hist_adv <= next_expected_pc(pc_now, redirect_jal_i, redirect_branch_i,
                                         branch_cmp_i, redirect_jalr_i, jalr_base_i,
                                         trap_i, trap_vec_i, mem_pc_i, mem_imm_i, !stall_i);
            exp_pc   <= next_expected_pc(pc_now, redirect_jal_i, redirect_branch_i,
                                         branch_cmp_i, redirect_jalr_i, jalr_base_i,
                                         trap_i, trap_vec_i, mem_pc_i, mem_imm_i, 1'b0);
        end
    end

    // every delivery against the tracked pc and the memory contents
    always @(posedge clk) begin
        if (rst_n_i && inst_valid_o) begin
            delivered++;
            check_count++;
            if (inst_pc_o !== hist_pc) begin
                $display("FAILED inst_pc_o: expected %h, got %h", hist_pc, inst_pc_o);
                error_count++;
            end
            if (inst_o !== expected_inst(inst_pc_o)) begin
                $display("FAILED inst_o: expected %h, got %h", expected_inst(inst_pc_o), inst_o);
                error_count++;
            end
        end
    end

    task automatic finish_run();
        int total;
        total = error_count + mem_errors;
        $display("checks %0d, deliveries %0d, errors %0d (testbench %0d, memory model %0d)",
                 check_count, delivered, total, error_count, mem_errors);
        if (total == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    task automatic wait_delivery(output logic [XLEN-1:0] pc);
        int   cycles;
        logic found;
        cycles = 0;
        found  = 1'b0;
        pc     = '0;
        while (!found && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
            if (inst_valid_o) begin
                found = 1'b1;
                pc    = inst_pc_o;
            end
        end
        if (!found) begin
            $display("timeout after %0d cycles waiting for an instruction delivery", cycles);
            error_count++;
            finish_run();
        end
    endtask

    task automatic wait_addr_transfer(output logic [XLEN-1:0] addr);
        int   cycles;
        logic found;
        cycles = 0;
        found  = 1'b0;
        addr   = '0;
        while (!found && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
            if (rd_addr_valid_o && rd_addr_ready_i) begin
                found = 1'b1;
                addr  = rd_addr_o;
            end
        end
        if (!found) begin
            $display("timeout after %0d cycles waiting for a read address transfer", cycles);
            error_count++;
            finish_run();
        end
    endtask

    task automatic expect_delivery(input logic [XLEN-1:0] want, input string what);
        logic [XLEN-1:0] got;
        wait_delivery(got);
        check_count++;
        if (got !== want) begin
            $display("FAILED inst_pc_o: expected %h, got %h (%s)", want, got, what);
            error_count++;
        end
    endtask

    // one-cycle control pulse, called right after a rising edge
    task automatic pulse_control(
        input logic            jal,
        input logic            br,
        input logic            jalr,
        input logic            trap,
        input logic [XLEN-1:0] cmp,
        input logic [XLEN-1:0] base,
        input logic [XLEN-1:0] vec,
        input logic [XLEN-1:0] mpc,
        input logic [XLEN-1:0] imm
    );
        redirect_jal_i    <= jal;
        redirect_branch_i <= br;
        redirect_jalr_i   <= jalr;
        trap_i            <= trap;
        branch_cmp_i      <= cmp;
        jalr_base_i       <= base;
        trap_vec_i        <= vec;
        mem_pc_i          <= mpc;
        mem_imm_i         <= imm;
        @(posedge clk);
        redirect_jal_i    <= 1'b0;
        redirect_branch_i <= 1'b0;
        redirect_jalr_i   <= 1'b0;
        trap_i            <= 1'b0;
    endtask

    initial begin
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] stale;
        logic [XLEN-1:0] held;
        logic [XLEN-1:0] tgt;
        logic [31:0]     r;
        seed              = SEED_INIT;
        error_count       = 0;
        check_count       = 0;
        delivered         = 0;
        rst_n_i           = 1'b0;
        redirect_jal_i    = 1'b0;
        redirect_branch_i = 1'b0;
        branch_cmp_i      = '0;
        redirect_jalr_i   = 1'b0;
        jalr_base_i       = '0;
        trap_i            = 1'b0;
        trap_vec_i        = '0;
        mem_pc_i          = '0;
        mem_imm_i         = '0;
        stall_i           = 1'b0;
        repeat (16) @(posedge clk);
        rst_n_i <= 1'b1;

        // straight-line fetch from the reset address
        tgt = RESET_PC;
        for (int i = 0; i < 6; i++) begin
            expect_delivery(tgt, "sequential");
            tgt = tgt + INST_STEP;
        end

        // each redirect kind, issued right after a delivery
        pulse_control(1'b1, 1'b0, 1'b0, 1'b0, '0, '0, '0, 64'h8000_1000, 64'h40);
        expect_delivery(64'h8000_1040, "jal");
        expect_delivery(64'h8000_1044, "after jal");
        pulse_control(1'b0, 1'b1, 1'b0, 1'b0, '0, '0, '0, 64'h8000_2000, -64'sd256);
        expect_delivery(64'h8000_1f00, "taken branch");
        pulse_control(1'b0, 1'b1, 1'b0, 1'b0, 64'h1, '0, '0, 64'h8000_2000, 64'h80);
        expect_delivery(64'h8000_1f04, "branch not taken");
        pulse_control(1'b0, 1'b0, 1'b1, 1'b0, '0, 64'h8000_3001, '0, '0, 64'h10);
        expect_delivery(64'h8000_3010, "jalr");
        pulse_control(1'b0, 1'b0, 1'b0, 1'b1, '0, '0, 64'h8000_0400, '0, '0);
        expect_delivery(64'h8000_0400, "trap");
        // jal and trap together
        pulse_control(1'b1, 1'b0, 1'b0, 1'b1, '0, '0, 64'h8000_0800, 64'h8000_4000, 64'h8);
        expect_delivery(64'h8000_4008, "jal over trap");

        // trap while a read is outstanding, its beat must be dropped
        wait_addr_transfer(stale);
        pulse_control(1'b0, 1'b0, 1'b0, 1'b1, '0, '0, 64'h8000_5000, '0, '0);
        wait_delivery(pc);
        check_count++;
        if (pc === stale) begin
            $display("stale read of address %h was delivered after a redirect", stale);
            error_count++;
        end
        if (pc !== 64'h8000_5000) begin
            $display("FAILED inst_pc_o: expected %h, got %h", 64'h8000_5000, pc);
            error_count++;
        end

        // stall repeats the same fetch
        stall_i <= 1'b1;
        wait_delivery(held);
        for (int i = 0; i < 3; i++) begin
            expect_delivery(held, "stalled");
        end
        stall_i <= 1'b0;
        expect_delivery(held, "stall release");
        expect_delivery(held + INST_STEP, "advance after stall");

        // random redirects and stalls at arbitrary points of the fetch loop
        for (int n = 0; n < 80; n++) begin
            r = $random(seed);
            repeat (r[2:0]) @(posedge clk);
            tgt = RESET_PC + {48'd0, r[23:9], 1'b0};
            case (r[6:4])
                3'd0: pulse_control(1'b1, 1'b0, 1'b0, 1'b0, '0, '0, '0, tgt, 64'h20);
                3'd1: pulse_control(1'b0, 1'b1, 1'b0, 1'b0, '0, '0, '0, tgt, 64'h6);
                3'd2: pulse_control(1'b0, 1'b1, 1'b0, 1'b0, 64'h5, '0, '0, tgt, 64'h6);
                3'd3: pulse_control(1'b0, 1'b0, 1'b1, 1'b0, '0, tgt + 1, '0, '0, 64'h6);
                3'd4: pulse_control(1'b0, 1'b0, 1'b0, 1'b1, '0, '0, tgt, '0, '0);
                3'd5: stall_i <= !stall_i;
                default: wait_delivery(pc);
            endcase
        end
        stall_i <= 1'b0;
        wait_delivery(pc);

        if (delivered < 30) begin
            $display("only %0d instructions were delivered over the whole run", delivered);
            error_count++;
        end
        finish_run();
    end

endmodule
